// File: Makefile
# Verilator build and run of the PMA checker testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   list these targets"

test:
	verilator --binary --timing --assert -f flist.f --top-module pma_checker_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vpma_checker_tb)"; echo "$$out"; \
	  echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir

// File: bench/pma_checker_properties.sv
//////////////////////////////////////////////////
// Timing and status checks for the PMA checker.
// Bound into the top level; it assumes the
// request payload is held with its valid strobe.
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pma_checker_properties
  import pma_pkg::*;
(
  input wire              clk,
  input wire              arst_n_i,
  input wire              req_valid_i,
  input wire pma_req_t    req_i,
  input wire              status_valid_o,
  input wire pma_status_t status_o
);

  // Fixed latency of three cycles from request to status
  assert property (@(posedge clk) disable iff (!arst_n_i)
    status_valid_o == $past(req_valid_i, 3))
    else $error("status valid does not follow the request strobe by three cycles");

  assert property (@(posedge clk) disable iff (!arst_n_i)
    status_valid_o && status_o.override_dm |-> status_o.allow)
    else $error("debug override without allow");

  // The kind of the access in stage 3 was on the inputs three edges back
  assert property (@(posedge clk) disable iff (!arst_n_i)
    status_valid_o && ($past(req_i.kind, 3) != ACC_STORE) |-> !status_o.bufferable)
    else $error("bufferable set on a fetch or a load");

endmodule

bind pma_checker_top pma_checker_properties i_properties (.*);

`default_nettype wire

// File: bench/pma_checker_tb.sv
//////////////////////////////////////////////////
// Directed testbench for the PMA checker.
// It uses its own four-region table and debug
// region. jvt_base_i only changes while idle.
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pma_checker_tb
  import pma_pkg::*;
();

  localparam logic [31:0] DM_START    = 32'h1000_0800;
  localparam logic [31:0] DM_END      = 32'h1000_0BFF;
  localparam int          NUM_REGIONS = 4;
  localparam int          TIMEOUT     = 20;
  localparam int          BURST_LEN   = 24;

  // Bounds are word addresses and the flag nibble is main, bufferable, cacheable, integrity
  localparam pma_cfg_t REGIONS [MAX_REGIONS] = '{
    0: {30'h000_0000, 30'h000_4000, 4'b1010},
    1: {30'h000_2000, 30'h000_8000, 4'b0101},
    2: {30'h400_0000, 30'h400_0400, 4'b0000},
    3: {30'h800_0000, 30'h800_0000, 4'b1111},
    default: '0
  };

  logic        clk;
  logic        arst_n_i;
  logic        req_valid_i;
  pma_req_t    req_i;
  logic [31:0] jvt_base_i;
  logic        status_valid_o;
  pma_status_t status_o;
  logic [31:0] lcg_state;
  int          errors;
  int          tests_run;
  int          tests_failed;

  pma_checker_top #(
    .DM_REGION_START (DM_START),
    .DM_REGION_END   (DM_END),
    .PMA_NUM_REGIONS (NUM_REGIONS),
    .PMA_CFG         (REGIONS)
  ) i_dut (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .req_valid_i    (req_valid_i),
    .req_i          (req_i),
    .jvt_base_i     (jvt_base_i),
    .status_valid_o (status_valid_o),
    .status_o       (status_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic pma_req_t make_req(input logic [31:0] addr, input access_kind_e kind,
                                        input logic mis, input logic pp, input logic dbg);
    return '{addr, kind, mis, pp, dbg};
  endfunction

  // Resolution rules applied to the table above
  function automatic pma_status_t expected_status(input pma_req_t r, input logic [31:0] jvt);
    pma_status_t s;
    pma_cfg_t    c;
    s = '0;
    s.addr = r.addr;
    for (int i = 0; i < NUM_REGIONS; i++) begin
      if (64'(r.addr) >= 64'(REGIONS[i].word_addr_low) * 4 &&
          64'(r.addr) < 64'(REGIONS[i].word_addr_high) * 4) begin
        s.match_list[i] = 1'b1;
        if (!s.have_match) begin
          s.have_match = 1'b1;
          s.match_idx  = 4'(i);
        end
      end
    end
    s.accesses_dmregion = (r.addr >= DM_START) && (r.addr <= DM_END);
    s.override_dm       = r.dbg && s.accesses_dmregion;
    c = '0;
    if (s.override_dm) c.main = 1'b1;
    else if (s.have_match) c = REGIONS[s.match_idx];
    else c.main = (NUM_REGIONS == 0);
    s.main       = c.main;
    s.bufferable = c.bufferable && (r.kind == ACC_STORE);
    s.cacheable  = c.cacheable;
    s.integrity  = c.integrity;
    if (s.override_dm) s.allow = 1'b1;
    else if (r.kind == ACC_INSTR) s.allow = c.main;
    else s.allow = c.main || (!r.misaligned && !r.pushpop);
    s.accesses_jvt = (64'(r.addr) >= 64'(jvt)) && (64'(r.addr) <= 64'(jvt) + 1020);
    return s;
  endfunction

  task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic compare_status(input pma_status_t got, input pma_status_t exp);
    check_field("addr", got.addr, exp.addr);
    check_field("match_list", 32'(got.match_list), 32'(exp.match_list));
    check_field("have_match", 32'(got.have_match), 32'(exp.have_match));
    check_field("match_idx", 32'(got.match_idx), 32'(exp.match_idx));
    check_field("allow", 32'(got.allow), 32'(exp.allow));
    check_field("main", 32'(got.main), 32'(exp.main));
    check_field("bufferable", 32'(got.bufferable), 32'(exp.bufferable));
    check_field("cacheable", 32'(got.cacheable), 32'(exp.cacheable));
    check_field("integrity", 32'(got.integrity), 32'(exp.integrity));
    check_field("override_dm", 32'(got.override_dm), 32'(exp.override_dm));
    check_field("accesses_dmregion", 32'(got.accesses_dmregion), 32'(exp.accesses_dmregion));
    check_field("accesses_jvt", 32'(got.accesses_jvt), 32'(exp.accesses_jvt));
  endtask

  // One request through the pipe, checked for latency and against the model
  task automatic access(input pma_req_t r, output pma_status_t st);
    int waited;
    @(posedge clk);
    req_valid_i <= 1'b1;
    req_i       <= r;
    @(posedge clk);
    req_valid_i <= 1'b0;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!status_valid_o && waited < TIMEOUT);
    st = status_o;
    if (!status_valid_o) begin
      $display("no status came back within %0d cycles, at %0t ns", TIMEOUT, $time);
      errors++;
    end else begin
      if (waited != 3) begin
        $display("error at %0t ns: status after %0d cycles, expected 3", $time, waited);
        errors++;
      end
      compare_status(st, expected_status(r, jvt_base_i));
    end
  endtask

  task automatic report_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d errors", name, errors - err_start);
    end
  endtask

  task automatic test_priority();
    logic [31:0] bounds [4] = '{32'h0001_0000, 32'h0002_0000, 32'h1000_1000, 32'h2000_0000};
    pma_status_t st;
    int          err_start;
    err_start = errors;
    // Overlap of regions 0 and 1 goes to region 0
    access(make_req(32'h8000 | (next_random() & 32'h7FFC), ACC_LOAD, 1'b0, 1'b0, 1'b0), st);
    check_field("match_idx", 32'(st.match_idx), 32'd0);
    check_field("match_list", 32'(st.match_list[1:0]), 32'd3);
    access(make_req(32'h1_0000 | (next_random() & 32'hFFFC), ACC_LOAD, 1'b0, 1'b0, 1'b0), st);
    check_field("match_idx", 32'(st.match_idx), 32'd1);
    // The upper bound of each region lies outside it, and region 3 is empty
    for (int i = 0; i < 4; i++) begin
      access(make_req(bounds[i], ACC_LOAD, 1'b0, 1'b0, 1'b0), st);
      check_field("match_list", 32'(st.match_list[i]), 32'd0);
    end
    report_test("region priority", err_start);
  endtask

  task automatic test_default_allow();
    pma_status_t st;
    logic [31:0] addr;
    int          err_start;
    err_start = errors;
    addr = 32'h4000_0000 | (next_random() & 32'h0FFF_FFFC);
    access(make_req(addr, ACC_LOAD, 1'b1, 1'b0, 1'b0), st);
    check_field("main", 32'(st.main), 32'd0);
    check_field("allow", 32'(st.allow), 32'd0);
    access(make_req(addr, ACC_STORE, 1'b0, 1'b1, 1'b0), st);
    check_field("allow", 32'(st.allow), 32'd0);
    access(make_req(addr, ACC_STORE, 1'b0, 1'b0, 1'b0), st);
    check_field("allow", 32'(st.allow), 32'd1);
    access(make_req(addr, ACC_INSTR, 1'b0, 1'b0, 1'b0), st);
    check_field("allow", 32'(st.allow), 32'd0);
    report_test("default and allow", err_start);
  endtask

  task automatic test_debug_override();
    pma_status_t st;
    logic [31:0] addr;
    int          err_start;
    err_start = errors;
    // The debug region sits inside the peripheral region 2
    addr = DM_START + (next_random() & 32'h3FC);
    access(make_req(addr, ACC_STORE, 1'b1, 1'b0, 1'b1), st);
    check_field("override_dm", 32'(st.override_dm), 32'd1);
    check_field("main", 32'(st.main), 32'd1);
    check_field("allow", 32'(st.allow), 32'd1);
    access(make_req(addr, ACC_STORE, 1'b1, 1'b0, 1'b0), st);
    check_field("override_dm", 32'(st.override_dm), 32'd0);
    check_field("main", 32'(st.main), 32'd0);
    check_field("allow", 32'(st.allow), 32'd0);
    check_field("match_idx", 32'(st.match_idx), 32'd2);
    report_test("debug override", err_start);
  endtask

  task automatic test_bufferable();
    access_kind_e kinds [3] = '{ACC_STORE, ACC_LOAD, ACC_INSTR};
    pma_status_t  st;
    logic [31:0]  addr;
    int           err_start;
    err_start = errors;
    addr = 32'h1_0000 | (next_random() & 32'hFFFC);
    for (int k = 0; k < 3; k++) begin
      access(make_req(addr, kinds[k], 1'b0, 1'b0, 1'b0), st);
      check_field("bufferable", 32'(st.bufferable), 32'(kinds[k] == ACC_STORE));
    end
    report_test("bufferable masking", err_start);
  endtask

  task automatic test_jvt_window();
    int          offsets [4] = '{0, 1020, -4, 1024};
    pma_status_t st;
    logic [31:0] base;
    int          err_start;
    err_start = errors;
    base = 32'h4000 | (next_random() & 32'h3FFC);
    @(posedge clk);
    jvt_base_i <= base;
    for (int i = 0; i < 4; i++) begin
      access(make_req(base + 32'(offsets[i]), ACC_INSTR, 1'b0, 1'b0, 1'b0), st);
      check_field("accesses_jvt", 32'(st.accesses_jvt), 32'(i < 2));
    end
    report_test("jvt window", err_start);
  endtask

  task automatic test_burst();
    pma_req_t    reqs [BURST_LEN];
    logic [31:0] a;
    logic [31:0] f;
    int          n;
    int          waited;
    int          err_start;
    err_start = errors;
    for (int i = 0; i < BURST_LEN; i++) begin
      a = next_random();
      f = next_random();
      // Steer most addresses into the table or the debug region
      if (f[0]) a = a & 32'h0003_FFFF;
      else if (f[1]) a = DM_START + (a & 32'h3FF);
      reqs[i] = make_req(a, access_kind_e'(2'(f[9:8] % 3)), f[4], f[5], f[6]);
    end
    @(negedge clk);
    fork
      begin
        for (int i = 0; i < BURST_LEN; i++) begin
          @(posedge clk);
          req_valid_i <= 1'b1;
          req_i       <= reqs[i];
        end
        @(posedge clk);
        req_valid_i <= 1'b0;
      end
      begin
        // Request i is on the inputs at negedge i+1
        n = 0;
        for (int i = 0; i < BURST_LEN; i++) begin
          waited = 0;
          do begin
            @(negedge clk);
            n++;
            waited++;
          end while (!status_valid_o && waited < TIMEOUT);
          if (!status_valid_o) begin
            $display("burst result %0d did not arrive within %0d cycles", i, TIMEOUT);
            errors++;
            break;
          end
          if (n != i + 4) begin
            $display("error at %0t ns: burst result %0d came %0d cycles after its request",
                     $time, i, n - i - 1);
            errors++;
          end
          compare_status(status_o, expected_status(reqs[i], jvt_base_i));
        end
      end
    join
    report_test("pipelined burst", err_start);
  endtask

  initial begin
    arst_n_i     = 1'b0;
    req_valid_i  = 1'b0;
    req_i        = '0;
    jvt_base_i   = 32'hF000_0000;
    lcg_state    = 32'hc7f4_697a;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (8) @(posedge clk);
    arst_n_i <= 1'b1;
    test_priority();
    test_default_allow();
    test_debug_override();
    test_bufferable();
    test_jvt_window();
    test_burst();
    $display("%0d of %0d tests clean, %0d errors", tests_run - tests_failed, tests_run, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
verilog/pma_pkg.sv
verilog/pma_req_stage.sv
verilog/pma_region_match.sv
verilog/pma_attr_resolve.sv
verilog/pma_checker_top.sv
bench/pma_checker_properties.sv
bench/pma_checker_tb.sv

// File: verilog/pma_attr_resolve.sv
//////////////////////////////////////////////////
// Third stage, attribute resolution.
// jvt_base_i is a level and is sampled here, so
// it must be stable while accesses are in flight.
// The debug region bounds are both inclusive.
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pma_attr_resolve
  import pma_pkg::*;
#(
  parameter logic [31:0] DM_REGION_START = 32'h1A11_0000,
  parameter logic [31:0] DM_REGION_END   = 32'h1A11_0FFF,
  parameter int          PMA_NUM_REGIONS = 0,
  parameter pma_cfg_t    PMA_CFG [MAX_REGIONS] = '{default: '0}
)(
  input  wire             clk,
  input  wire             arst_n_i,

  input  wire             match_valid_i,
  input  wire pma_match_t match_i,
  input  wire [31:0]      jvt_base_i,

  output logic            status_valid_o,
  output pma_status_t     status_o
);

  // Byte span of the jump vector table window above its base
  localparam int JVT_SPAN = 1020;

  // Without a table everything is main memory, otherwise unmatched space is I/O
  localparam pma_cfg_t CFG_DEFAULT = '{
    word_addr_low:  '0,
    word_addr_high: '0,
    main:           (PMA_NUM_REGIONS == 0),
    bufferable:     1'b0,
    cacheable:      1'b0,
    integrity:      1'b0
  };

  localparam pma_cfg_t CFG_DEBUG = '{
    word_addr_low:  '0,
    word_addr_high: '0,
    main:           1'b1,
    bufferable:     1'b0,
    cacheable:      1'b0,
    integrity:      1'b0
  };

  pma_req_t    req;
  pma_cfg_t    cfg_eff;
  logic        accesses_dmregion;
  logic        override_dm;
  logic        accesses_jvt;
  logic        allow;
  logic [32:0] jvt_top;
  pma_status_t status_d;

  assign req = match_i.req;

  assign accesses_dmregion = (DM_REGION_START <= req.addr) && (req.addr <= DM_REGION_END);
  assign override_dm       = req.dbg && accesses_dmregion;

  always_comb begin
    if (override_dm) begin
      cfg_eff = CFG_DEBUG;
    end else if (match_i.have_match) begin
      cfg_eff = PMA_CFG[match_i.match_idx];
    end else begin
      cfg_eff = CFG_DEFAULT;
    end
    // Only stores may be buffered
    if (req.kind != ACC_STORE) begin
      cfg_eff.bufferable = 1'b0;
    end
  end

  // Fetches need main memory, data accesses only when misaligned or push/pop
  always_comb begin
    if (override_dm) begin
      allow = 1'b1;
    end else if (req.kind == ACC_INSTR) begin
      allow = cfg_eff.main;
    end else begin
      allow = cfg_eff.main || (!req.misaligned && !req.pushpop);
    end
  end

  // 33-bit top so a base near the end of memory does not wrap
  assign jvt_top      = {1'b0, jvt_base_i} + 33'(JVT_SPAN);
  assign accesses_jvt = (jvt_base_i <= req.addr) && ({1'b0, req.addr} <= jvt_top);

  always_comb begin
    status_d.addr              = req.addr;
    status_d.match_list        = match_i.match_list;
    status_d.have_match        = match_i.have_match;
    status_d.match_idx         = match_i.match_idx;
    status_d.allow             = allow;
    status_d.main              = cfg_eff.main;
    status_d.bufferable        = cfg_eff.bufferable;
    status_d.cacheable         = cfg_eff.cacheable;
    status_d.integrity         = cfg_eff.integrity;
    status_d.override_dm       = override_dm;
    status_d.accesses_dmregion = accesses_dmregion;
    status_d.accesses_jvt      = accesses_jvt;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_valid_o <= 1'b0;
    end else begin
      status_valid_o <= match_valid_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_o <= '0;
    end else if (match_valid_i) begin
      status_o <= status_d;
    end
  end

endmodule

`default_nettype wire

// File: verilog/pma_checker_top.sv
//////////////////////////////////////////////////
// PMA checker, three cycles from request to
// status, one request per cycle, results in
// order. There is no stall and no handshake.
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pma_checker_top
  import pma_pkg::*;
#(
  parameter logic [31:0] DM_REGION_START = 32'h1A11_0000,
  parameter logic [31:0] DM_REGION_END   = 32'h1A11_0FFF,
  parameter int          PMA_NUM_REGIONS = 0,
  parameter pma_cfg_t    PMA_CFG [MAX_REGIONS] = '{default: '0}
)(
  input  wire              clk,
  input  wire              arst_n_i,

  input  wire              req_valid_i,
  input  wire pma_req_t    req_i,
  input  wire [31:0]       jvt_base_i,

  output wire              status_valid_o,
  output wire pma_status_t status_o
);

  wire             req_valid;
  wire pma_req_t   req_q;
  wire             match_valid;
  wire pma_match_t match_q;

  pma_req_stage i_req_stage (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_valid_o (req_valid),
    .req_o       (req_q)
  );

  pma_region_match #(
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG)
  ) i_region_match (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .req_valid_i   (req_valid),
    .req_i         (req_q),
    .match_valid_o (match_valid),
    .match_o       (match_q)
  );

  pma_attr_resolve #(
    .DM_REGION_START (DM_REGION_START),
    .DM_REGION_END   (DM_REGION_END),
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG)
  ) i_attr_resolve (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .match_valid_i  (match_valid),
    .match_i        (match_q),
    .jvt_base_i     (jvt_base_i),
    .status_valid_o (status_valid_o),
    .status_o       (status_o)
  );

endmodule

`default_nettype wire

// File: verilog/pma_pkg.sv
//////////////////////////////////////////////////
// Shared types for the PMA checker pipeline.
// Region bounds are word addresses, so a region
// always starts and ends on a 4-byte boundary.
// The region table holds at most MAX_REGIONS.
//////////////////////////////////////////////////

`default_nettype none

package pma_pkg;

  // Upper bound on region table entries and width of the match list
  localparam int MAX_REGIONS = 16;

  // One region of the attribute table
  // The region covers word_addr_low*4 up to but excluding word_addr_high*4
  typedef struct packed {
    logic [29:0] word_addr_low;
    logic [29:0] word_addr_high;
    logic        main;
    logic        bufferable;
    logic        cacheable;
    logic        integrity;
  } pma_cfg_t;

  // Kind of access, so that one checker serves fetches, loads and stores
  typedef enum logic [1:0] {
    ACC_INSTR = 2'd0,
    ACC_LOAD  = 2'd1,
    ACC_STORE = 2'd2
  } access_kind_e;

  // Access request as seen at the pipeline input
  typedef struct packed {
    logic [31:0]  addr;
    access_kind_e kind;
    logic         misaligned;
    logic         pushpop;
    logic         dbg;
  } pma_req_t;

  // Result of the region lookup together with the request it belongs to
  typedef struct packed {
    pma_req_t               req;
    logic [MAX_REGIONS-1:0] match_list;
    logic                   have_match;
    logic [3:0]             match_idx;
  } pma_match_t;

  // Final classification of one access
  typedef struct packed {
    logic [31:0]            addr;
    logic [MAX_REGIONS-1:0] match_list;
    logic                   have_match;
    logic [3:0]             match_idx;
    logic                   allow;
    logic                   main;
    logic                   bufferable;
    logic                   cacheable;
    logic                   integrity;
    logic                   override_dm;
    logic                   accesses_dmregion;
    logic                   accesses_jvt;
  } pma_status_t;

endpackage

`default_nettype wire

// File: verilog/pma_region_match.sv
//////////////////////////////////////////////////
// Second stage, region lookup.
// Regions are fixed by PMA_CFG at build time and
// only the first PMA_NUM_REGIONS entries count.
// With overlapping regions the lowest index wins.
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pma_region_match
  import pma_pkg::*;
#(
  parameter int       PMA_NUM_REGIONS = 0,
  parameter pma_cfg_t PMA_CFG [MAX_REGIONS] = '{default: '0}
)(
  input  wire           clk,
  input  wire           arst_n_i,

  input  wire           req_valid_i,
  input  wire pma_req_t req_i,

  output logic          match_valid_o,
  output pma_match_t    match_o
);

  logic [MAX_REGIONS-1:0] match_list;
  logic                   have_match;
  logic [3:0]             match_idx;
  logic [33:0]            addr_ext;

  // Compare on 34 bits so the upper bound never wraps
  assign addr_ext = {2'b00, req_i.addr};

  for (genvar i = 0; i < MAX_REGIONS; i++) begin : gen_match
    logic [33:0] low;
    logic [33:0] high;

    assign low  = {2'b00, PMA_CFG[i].word_addr_low, 2'b00};
    assign high = {2'b00, PMA_CFG[i].word_addr_high, 2'b00};

    // Entries past the configured count never match
    assign match_list[i] = (i < PMA_NUM_REGIONS) && (low <= addr_ext) && (addr_ext < high);
  end

  // Priority encoder, scanned from the top so the lowest hit is kept last
  always_comb begin
    have_match = 1'b0;
    match_idx  = '0;
    for (int i = MAX_REGIONS - 1; i >= 0; i--) begin
      if (match_list[i]) begin
        have_match = 1'b1;
        match_idx  = 4'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      match_valid_o <= 1'b0;
    end else begin
      match_valid_o <= req_valid_i;
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      match_o <= '0;
    end else if (req_valid_i) begin
      match_o.req        <= req_i;
      match_o.match_list <= match_list;
      match_o.have_match <= have_match;
      match_o.match_idx  <= match_idx;
    end
  end

endmodule

`default_nettype wire

// File: verilog/pma_req_stage.sv
//////////////////////////////////////////////////
// First pipeline stage, registers the request.
// No back-pressure: every valid strobe is taken.
// The payload holds its value in idle cycles.
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pma_req_stage
  import pma_pkg::*;
(
  input  wire           clk,
  input  wire           arst_n_i,

  input  wire           req_valid_i,
  input  wire pma_req_t req_i,

  output logic          req_valid_o,
  output pma_req_t      req_o
);

  // Valid bit, one cycle behind the input strobe
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_valid_o <= 1'b0;
    end else begin
      req_valid_o <= req_valid_i;
    end
  end

  // Only load the payload with a live request, which keeps the downstream
  // comparators quiet while the pipeline is idle
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_o <= '0;
    end else if (req_valid_i) begin
      req_o <= req_i;
    end
  end

endmodule

`default_nettype wire
